// ==== hdl/axi_rd_cfg.svh ====
`ifndef AXI_RD_CFG_SVH
`define AXI_RD_CFG_SVH

// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 128
`define AXI_ID_W 4
`define AXI_LEN_W 8

// Inclusive address window of the memory target
`define TGT0_ADDR_BASE 32'h0000_1000
`define TGT0_ADDR_LIMIT 32'h0000_1FFF

// Response codes
`define RESP_OKAY 2'b00
`define RESP_DECERR 2'b11

`endif

// ==== hdl/axi_rd_pkg.sv ====
`include "axi_rd_cfg.svh"

package axi_rd_pkg;

	// Byte address
	typedef logic [`AXI_ADDR_W-1:0] addr_t;

	// One data beat
	typedef logic [`AXI_DATA_W-1:0] data_t;

	typedef logic [`AXI_ID_W-1:0] id_t;

	// Beats in the burst minus one
	typedef logic [`AXI_LEN_W-1:0] len_t;

	// Bytes per beat as log2
	typedef logic [2:0] size_t;

	typedef logic [1:0] burst_t;
	typedef logic [1:0] resp_t;

endpackage

// ==== hdl/rd_ic_pkg.sv ====
package rd_ic_pkg;

	// Target picked by the address decode
	typedef enum logic [1:0] {
		TGT_MEM,
		TGT_DECERR,
		TGT_NONE
	} tgt_sel_t;

	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_DECODE,
		REQ_ISSUE
	} req_state_t;

	// Per-source read return tracking
	typedef enum logic [1:0] {
		RET_IDLE,
		RET_WAIT_GNT,
		RET_CONNECTED
	} ret_state_t;

	// Memory target and decode-error target
	localparam int N_SRC = 2;

endpackage

// ==== hdl/axi_rd_if.sv ====
`timescale 1ns/1ps

interface axi_rd_if;
	import axi_rd_pkg::*;

	// AR channel
	logic arvalid;
	logic arready;
	addr_t araddr;
	id_t arid;
	len_t arlen;
	size_t arsize;
	burst_t arburst;

	// R channel
	logic rvalid;
	logic rready;
	data_t rdata;
	id_t rid;
	resp_t rresp;
	logic rlast;

	modport mgr (
		output arvalid, araddr, arid, arlen, arsize, arburst, rready,
		input arready, rvalid, rdata, rid, rresp, rlast
	);

	modport sub (
		input arvalid, araddr, arid, arlen, arsize, arburst, rready,
		output arready, rvalid, rdata, rid, rresp, rlast
	);

	modport mon (
		input arvalid, arready, araddr, arid, arlen, arsize, arburst,
		input rvalid, rready, rdata, rid, rresp, rlast
	);

endinterface

// ==== hdl/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int N_REQ = 2
) (
	input logic clk,
	input logic rstn,
	input logic [N_REQ-1:0] req_i,
	output logic [N_REQ-1:0] gnt_o
);

	// One-hot copy of the most recent grant
	logic [N_REQ-1:0] last_gnt;

	logic [N_REQ-1:0] above_mask;
	logic [N_REQ-1:0] masked_req;
	logic [N_REQ-1:0] pick_masked;
	logic [N_REQ-1:0] pick_any;
	logic [N_REQ-1:0] pick;

	// Requesters strictly above the last grant
	assign above_mask = ~((last_gnt << 1) - 1'b1);
	assign masked_req = req_i & above_mask;

	// Isolate the lowest set bit
	assign pick_masked = masked_req & (~masked_req + 1'b1);
	assign pick_any = req_i & (~req_i + 1'b1);

	assign pick = (|masked_req) ? pick_masked : pick_any;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= '0;
			last_gnt <= '0;
		end else if (|gnt_o) begin
			// Hold until the owner drops its request
			if ((gnt_o & req_i) == '0) begin
				gnt_o <= '0;
			end
		end else if (|req_i) begin
			gnt_o <= pick;
			last_gnt <= pick;
		end
	end

endmodule

// ==== hdl/rd_request_stage.sv ====
`timescale 1ns/1ps
`include "axi_rd_cfg.svh"

module rd_request_stage (
	input logic clk,
	input logic rstn,
	input logic m_arvalid_i,
	input axi_rd_pkg::addr_t m_araddr_i,
	input axi_rd_pkg::id_t m_arid_i,
	input axi_rd_pkg::len_t m_arlen_i,
	input axi_rd_pkg::size_t m_arsize_i,
	input axi_rd_pkg::burst_t m_arburst_i,
	output logic m_arready_o,
	axi_rd_if.mgr mem,
	axi_rd_if.mgr err
);
	import axi_rd_pkg::*;
	import rd_ic_pkg::*;

	req_state_t state;
	tgt_sel_t sel;

	// Held request
	addr_t araddr_q;
	id_t arid_q;
	len_t arlen_q;
	size_t arsize_q;
	burst_t arburst_q;

	logic in_window;
	logic issue_done;

	assign m_arready_o = (state == REQ_IDLE);

	assign in_window = (araddr_q >= `TGT0_ADDR_BASE) && (araddr_q <= `TGT0_ADDR_LIMIT);

	assign mem.arvalid = (state == REQ_ISSUE) && (sel == TGT_MEM);
	assign err.arvalid = (state == REQ_ISSUE) && (sel == TGT_DECERR);

	assign issue_done = (mem.arvalid && mem.arready) || (err.arvalid && err.arready);

	// Both targets see the held payload, only arvalid is steered
	assign mem.araddr = araddr_q;
	assign mem.arid = arid_q;
	assign mem.arlen = arlen_q;
	assign mem.arsize = arsize_q;
	assign mem.arburst = arburst_q;
	assign err.araddr = araddr_q;
	assign err.arid = arid_q;
	assign err.arlen = arlen_q;
	assign err.arsize = arsize_q;
	assign err.arburst = arburst_q;

	always_ff @(posedge clk) begin
		if (m_arvalid_i && m_arready_o) begin
			araddr_q <= m_araddr_i;
			arid_q <= m_arid_i;
			arlen_q <= m_arlen_i;
			arsize_q <= m_arsize_i;
			arburst_q <= m_arburst_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= REQ_IDLE;
			sel <= TGT_NONE;
		end else begin
			case (state)
			REQ_IDLE: begin
				if (m_arvalid_i) begin
					state <= REQ_DECODE;
				end
			end
			REQ_DECODE: begin
				sel <= in_window ? TGT_MEM : TGT_DECERR;
				state <= REQ_ISSUE;
			end
			REQ_ISSUE: begin
				if (issue_done) begin
					sel <= TGT_NONE;
					state <= REQ_IDLE;
				end
			end
			default: state <= REQ_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/decerr_target.sv ====
`timescale 1ns/1ps
`include "axi_rd_cfg.svh"

module decerr_target (
	input logic clk,
	input logic rstn,
	axi_rd_if.sub bus
);
	import axi_rd_pkg::*;

	typedef enum logic {
		ERR_IDLE,
		ERR_DATA
	} err_state_t;

	err_state_t state;
	id_t id_q;
	len_t len_q;

	// Beats already returned in this burst
	len_t beat_cnt;

	logic last_beat;

	assign last_beat = (beat_cnt == len_q);

	assign bus.arready = (state == ERR_IDLE);
	assign bus.rvalid = (state == ERR_DATA);
	assign bus.rdata = '0;
	assign bus.rid = id_q;
	assign bus.rresp = `RESP_DECERR;
	assign bus.rlast = bus.rvalid && last_beat;

	always_ff @(posedge clk) begin
		if (bus.arvalid && bus.arready) begin
			id_q <= bus.arid;
			len_q <= bus.arlen;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ERR_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
			ERR_IDLE: begin
				if (bus.arvalid) begin
					beat_cnt <= '0;
					state <= ERR_DATA;
				end
			end
			ERR_DATA: begin
				if (bus.rready) begin
					if (last_beat) begin
						state <= ERR_IDLE;
					end else begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
			end
			default: state <= ERR_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/rd_return_mux.sv ====
`timescale 1ns/1ps

module rd_return_mux (
	input logic clk,
	input logic rstn,
	axi_rd_if.mon mem,
	axi_rd_if.mon err,
	output logic mem_rready_o,
	output logic err_rready_o,
	output logic m_rvalid_o,
	output axi_rd_pkg::data_t m_rdata_o,
	output axi_rd_pkg::id_t m_rid_o,
	output axi_rd_pkg::resp_t m_rresp_o,
	output logic m_rlast_o,
	input logic m_rready_i
);
	import axi_rd_pkg::*;
	import rd_ic_pkg::*;

	// Source 0 is the memory target, source 1 the decode-error target
	logic [N_SRC-1:0] src_rvalid;
	logic [N_SRC-1:0] src_rlast;
	logic [N_SRC-1:0] src_rready;
	logic [N_SRC-1:0] src_req;
	logic [N_SRC-1:0] src_gnt;
	logic [N_SRC-1:0] src_conn;
	data_t src_rdata [N_SRC];
	id_t src_rid [N_SRC];
	resp_t src_rresp [N_SRC];
	ret_state_t ret_state [N_SRC];

	assign src_rvalid = {err.rvalid, mem.rvalid};
	assign src_rlast = {err.rlast, mem.rlast};
	assign src_rdata = '{mem.rdata, err.rdata};
	assign src_rid = '{mem.rid, err.rid};
	assign src_rresp = '{mem.rresp, err.rresp};

	for (genvar i = 0; i < N_SRC; i++) begin : g_trk
		assign src_req[i] = (ret_state[i] != RET_IDLE);
		assign src_conn[i] = (ret_state[i] == RET_CONNECTED) && src_gnt[i];
		assign src_rready[i] = src_conn[i] && m_rready_i;

		always_ff @(posedge clk) begin
			if (!rstn) begin
				ret_state[i] <= RET_IDLE;
			end else begin
				case (ret_state[i])
				RET_IDLE: if (src_rvalid[i]) ret_state[i] <= RET_WAIT_GNT;
				RET_WAIT_GNT: if (src_gnt[i]) ret_state[i] <= RET_CONNECTED;
				RET_CONNECTED: begin
					if (src_rvalid[i] && src_rready[i] && src_rlast[i]) begin
						ret_state[i] <= RET_IDLE;
					end
				end
				default: ret_state[i] <= RET_IDLE;
				endcase
			end
		end
	end

	rr_arbiter #(
		.N_REQ(N_SRC)
	) u_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(src_req),
		.gnt_o(src_gnt)
	);

	assign mem_rready_o = src_rready[0];
	assign err_rready_o = src_rready[1];

	// At most one source is connected at a time
	always_comb begin
		m_rvalid_o = 1'b0;
		m_rdata_o = '0;
		m_rid_o = '0;
		m_rresp_o = '0;
		m_rlast_o = 1'b0;
		for (int i = 0; i < N_SRC; i++) begin
			if (src_conn[i]) begin
				m_rvalid_o = src_rvalid[i];
				m_rdata_o = src_rdata[i];
				m_rid_o = src_rid[i];
				m_rresp_o = src_rresp[i];
				m_rlast_o = src_rlast[i];
			end
		end
	end

endmodule

// ==== hdl/axi_rd_interconnect.sv ====
`timescale 1ns/1ps

module axi_rd_interconnect (
	input logic clk,
	input logic rstn,
	input logic m_arvalid_i,
	input axi_rd_pkg::addr_t m_araddr_i,
	input axi_rd_pkg::id_t m_arid_i,
	input axi_rd_pkg::len_t m_arlen_i,
	input axi_rd_pkg::size_t m_arsize_i,
	input axi_rd_pkg::burst_t m_arburst_i,
	output logic m_arready_o,
	output logic m_rvalid_o,
	output axi_rd_pkg::data_t m_rdata_o,
	output axi_rd_pkg::id_t m_rid_o,
	output axi_rd_pkg::resp_t m_rresp_o,
	output logic m_rlast_o,
	input logic m_rready_i,
	output logic s_arvalid_o,
	output axi_rd_pkg::addr_t s_araddr_o,
	output axi_rd_pkg::id_t s_arid_o,
	output axi_rd_pkg::len_t s_arlen_o,
	output axi_rd_pkg::size_t s_arsize_o,
	output axi_rd_pkg::burst_t s_arburst_o,
	input logic s_arready_i,
	input logic s_rvalid_i,
	input axi_rd_pkg::data_t s_rdata_i,
	input axi_rd_pkg::id_t s_rid_i,
	input axi_rd_pkg::resp_t s_rresp_i,
	input logic s_rlast_i,
	output logic s_rready_o
);

	axi_rd_if mem_if ();
	axi_rd_if err_if ();

	logic err_rready;

	// Memory target side runs out to the top-level ports
	assign s_arvalid_o = mem_if.arvalid;
	assign s_araddr_o = mem_if.araddr;
	assign s_arid_o = mem_if.arid;
	assign s_arlen_o = mem_if.arlen;
	assign s_arsize_o = mem_if.arsize;
	assign s_arburst_o = mem_if.arburst;
	assign mem_if.arready = s_arready_i;
	assign mem_if.rvalid = s_rvalid_i;
	assign mem_if.rdata = s_rdata_i;
	assign mem_if.rid = s_rid_i;
	assign mem_if.rresp = s_rresp_i;
	assign mem_if.rlast = s_rlast_i;
	assign mem_if.rready = s_rready_o;
	assign err_if.rready = err_rready;

	rd_request_stage u_req (
		.clk(clk),
		.rstn(rstn),
		.m_arvalid_i(m_arvalid_i),
		.m_araddr_i(m_araddr_i),
		.m_arid_i(m_arid_i),
		.m_arlen_i(m_arlen_i),
		.m_arsize_i(m_arsize_i),
		.m_arburst_i(m_arburst_i),
		.m_arready_o(m_arready_o),
		.mem(mem_if.mgr),
		.err(err_if.mgr)
	);

	decerr_target u_err (
		.clk(clk),
		.rstn(rstn),
		.bus(err_if.sub)
	);

	rd_return_mux u_ret (
		.clk(clk),
		.rstn(rstn),
		.mem(mem_if.mon),
		.err(err_if.mon),
		.mem_rready_o(s_rready_o),
		.err_rready_o(err_rready),
		.m_rvalid_o(m_rvalid_o),
		.m_rdata_o(m_rdata_o),
		.m_rid_o(m_rid_o),
		.m_rresp_o(m_rresp_o),
		.m_rlast_o(m_rlast_o),
		.m_rready_i(m_rready_i)
	);

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk_o,
	output logic rstn_o
);

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Reset held for three rising edges, released just after the third
	initial begin
		rstn_o = 1'b0;
		repeat (3) @(posedge clk_o);
		#1 rstn_o = 1'b1;
	end

endmodule

// ==== sim/axi_rd_props.sv ====
`timescale 1ns/1ps

module axi_rd_props (
	input logic clk,
	input logic rstn,
	input logic s_arvalid_i,
	input logic s_arready_i,
	input axi_rd_pkg::addr_t s_araddr_i,
	input axi_rd_pkg::id_t s_arid_i,
	input axi_rd_pkg::len_t s_arlen_i,
	input axi_rd_pkg::size_t s_arsize_i,
	input axi_rd_pkg::burst_t s_arburst_i,
	input logic m_rvalid_i,
	input logic m_rready_i,
	input axi_rd_pkg::data_t m_rdata_i,
	input axi_rd_pkg::id_t m_rid_i,
	input axi_rd_pkg::resp_t m_rresp_i,
	input logic m_rlast_i
);

	// Read by the testbench
	logic fail_seen = 1'b0;

	// Target request holds until accepted
	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		s_arvalid_i && !s_arready_i |=>
		s_arvalid_i && $stable({s_araddr_i, s_arid_i, s_arlen_i, s_arsize_i, s_arburst_i}))
	else begin
		fail_seen = 1'b1;
		$error("target AR request dropped or changed before its handshake");
	end

	// Stalled return beat holds
	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		m_rvalid_i && !m_rready_i |=>
		m_rvalid_i && $stable({m_rdata_i, m_rid_i, m_rresp_i, m_rlast_i}))
	else begin
		fail_seen = 1'b1;
		$error("master R beat dropped or changed while stalled");
	end

	a_rvalid_reset: assert property (@(posedge clk) !rstn |-> !m_rvalid_i)
	else begin
		fail_seen = 1'b1;
		$error("m_rvalid_o high during reset");
	end

endmodule

bind axi_rd_interconnect axi_rd_props u_props (
	.clk(clk),
	.rstn(rstn),
	.s_arvalid_i(s_arvalid_o),
	.s_arready_i(s_arready_i),
	.s_araddr_i(s_araddr_o),
	.s_arid_i(s_arid_o),
	.s_arlen_i(s_arlen_o),
	.s_arsize_i(s_arsize_o),
	.s_arburst_i(s_arburst_o),
	.m_rvalid_i(m_rvalid_o),
	.m_rready_i(m_rready_i),
	.m_rdata_i(m_rdata_o),
	.m_rid_i(m_rid_o),
	.m_rresp_i(m_rresp_o),
	.m_rlast_i(m_rlast_o)
);

// ==== sim/tb_axi_rd_interconnect.sv ====
`timescale 1ns/1ps
`include "axi_rd_cfg.svh"

module tb_axi_rd_interconnect;
	import axi_rd_pkg::*;

	localparam int TIMEOUT = 2000;

	// 16 bytes per beat, INCR
	localparam size_t AR_SIZE = 3'd4;
	localparam burst_t AR_BURST = 2'b01;

	// One expected return beat
	typedef struct packed {
		data_t data;
		resp_t resp;
		id_t id;
		logic last;
	} beat_t;

	logic clk;
	logic rstn;
	logic m_arvalid_i;
	addr_t m_araddr_i;
	id_t m_arid_i;
	len_t m_arlen_i;
	size_t m_arsize_i;
	burst_t m_arburst_i;
	logic m_arready_o;
	logic m_rvalid_o;
	data_t m_rdata_o;
	id_t m_rid_o;
	resp_t m_rresp_o;
	logic m_rlast_o;
	logic m_rready_i;
	logic s_arvalid_o;
	addr_t s_araddr_o;
	id_t s_arid_o;
	len_t s_arlen_o;
	size_t s_arsize_o;
	burst_t s_arburst_o;
	logic s_arready_i;
	logic s_rvalid_i;
	data_t s_rdata_i;
	id_t s_rid_i;
	resp_t s_rresp_i;
	logic s_rlast_i;
	logic s_rready_o;

	string test_name = "reset";

	// Outstanding reads, indexed by ID
	logic pend_valid [16] = '{default: 1'b0};
	addr_t pend_addr [16];
	len_t pend_len [16];
	int n_issued = 0;
	int n_done = 0;

	// Requests accepted by the memory target model
	addr_t tq_addr [$];
	id_t tq_id [$];
	len_t tq_len [$];
	int t_beat = 0;

	clk_gen u_clk (
		.clk_o(clk),
		.rstn_o(rstn)
	);

	axi_rd_interconnect u_dut (.*);

	task automatic report_error(input string msg);
		$display("ERROR %s: %s", test_name, msg);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string what, input logic [127:0] exp,
		input logic [127:0] act);
		$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic in_window(input addr_t addr);
		return (addr >= `TGT0_ADDR_BASE) && (addr <= `TGT0_ADDR_LIMIT);
	endfunction

	// Expected beat of a read as seen by the master
	function automatic beat_t ref_beat(input addr_t addr, input id_t id, input len_t len,
		input int beat);
		beat_t b;
		addr_t word;
		word = addr + addr_t'(beat * 16);
		if (in_window(addr)) begin
			b.data = {4{word}};
			b.resp = `RESP_OKAY;
		end else begin
			b.data = '0;
			b.resp = `RESP_DECERR;
		end
		b.id = id;
		b.last = (beat == int'(len));
		return b;
	endfunction

	task automatic send_read(input addr_t addr, input id_t id, input len_t len);
		int waited;
		logic accepted;
		waited = 0;
		while (pend_valid[id]) begin
			@(posedge clk);
			#1;
			waited++;
			assert (waited <= TIMEOUT) else report_error("read ID never retired");
		end
		m_arvalid_i = 1'b1;
		m_araddr_i = addr;
		m_arid_i = id;
		m_arlen_i = len;
		m_arsize_i = AR_SIZE;
		m_arburst_i = AR_BURST;
		waited = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = m_arready_o;
			@(posedge clk);
			#1;
			waited++;
			assert (waited <= TIMEOUT) else report_error("master AR request never accepted");
		end
		m_arvalid_i = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (n_done != n_issued) begin
			@(posedge clk);
			#1;
			waited++;
			assert (waited <= TIMEOUT) else report_error("outstanding reads did not complete");
		end
	endtask

	// Master back-pressure
	initial begin
		m_rready_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			m_rready_i = ($urandom_range(0, 3) != 0);
		end
	end

	// Memory target model, in-order returns with random gaps
	initial begin : target_model
		logic ar_hs;
		logic r_hs;
		s_arready_i = 1'b0;
		s_rvalid_i = 1'b0;
		s_rdata_i = '0;
		s_rid_i = '0;
		s_rresp_i = '0;
		s_rlast_i = 1'b0;
		forever begin
			@(negedge clk);
			ar_hs = s_arvalid_o && s_arready_i;
			r_hs = s_rvalid_i && s_rready_o;
			if (ar_hs) begin
				tq_addr.push_back(s_araddr_o);
				tq_id.push_back(s_arid_o);
				tq_len.push_back(s_arlen_o);
			end
			@(posedge clk);
			#1;
			if (r_hs) begin
				s_rvalid_i = 1'b0;
				if (s_rlast_i) begin
					void'(tq_addr.pop_front());
					void'(tq_id.pop_front());
					void'(tq_len.pop_front());
					t_beat = 0;
				end else begin
					t_beat++;
				end
			end
			s_arready_i = ($urandom_range(0, 3) != 0);
			if (!s_rvalid_i && tq_addr.size() > 0 && $urandom_range(0, 2) != 0) begin
				s_rvalid_i = 1'b1;
				s_rdata_i = {4{tq_addr[0] + addr_t'(t_beat * 16)}};
				s_rid_i = tq_id[0];
				s_rresp_i = `RESP_OKAY;
				s_rlast_i = (t_beat == int'(tq_len[0]));
			end
		end
	end

	// Scoreboard and beat compare
	initial begin : compare_proc
		beat_t exp;
		logic in_burst;
		id_t cur_id;
		int cur_beat;
		in_burst = 1'b0;
		cur_id = '0;
		cur_beat = 0;
		forever begin
			@(negedge clk);
			if (rstn) begin
				assert (!u_dut.u_props.fail_seen) else report_error("a bound assertion failed");
				if (m_arvalid_i && m_arready_o) begin
					pend_valid[m_arid_i] = 1'b1;
					pend_addr[m_arid_i] = m_araddr_i;
					pend_len[m_arid_i] = m_arlen_i;
					n_issued++;
				end
				if (s_arvalid_o) begin
					assert (in_window(s_araddr_o))
					else report_error("out-of-window address issued to the memory target");
					assert (s_araddr_o == pend_addr[s_arid_o])
					else report_mismatch("s_araddr", pend_addr[s_arid_o], s_araddr_o);
					assert (s_arlen_o == pend_len[s_arid_o])
					else report_mismatch("s_arlen", pend_len[s_arid_o], s_arlen_o);
					assert (s_arsize_o == AR_SIZE)
					else report_mismatch("s_arsize", AR_SIZE, s_arsize_o);
					assert (s_arburst_o == AR_BURST)
					else report_mismatch("s_arburst", AR_BURST, s_arburst_o);
				end
				if (m_rvalid_o && m_rready_i) begin
					if (!in_burst) begin
						assert (pend_valid[m_rid_o]) else report_error("beat with no outstanding read");
						in_burst = 1'b1;
						cur_id = m_rid_o;
						cur_beat = 0;
					end
					// A beat of another burst fails on rid
					exp = ref_beat(pend_addr[cur_id], cur_id, pend_len[cur_id], cur_beat);
					assert (m_rid_o == exp.id) else report_mismatch("rid", exp.id, m_rid_o);
					assert (m_rdata_o == exp.data) else report_mismatch("rdata", exp.data, m_rdata_o);
					assert (m_rresp_o == exp.resp) else report_mismatch("rresp", exp.resp, m_rresp_o);
					assert (m_rlast_o == exp.last) else report_mismatch("rlast", exp.last, m_rlast_o);
					if (m_rlast_o) begin
						pend_valid[cur_id] = 1'b0;
						in_burst = 1'b0;
						n_done++;
					end else begin
						cur_beat++;
					end
				end
			end
		end
	end

	initial begin
		addr_t addr;
		int cycles;
		int n;
		void'($urandom(52));
		m_arvalid_i = 1'b0;
		m_araddr_i = '0;
		m_arid_i = '0;
		m_arlen_i = '0;
		m_arsize_i = '0;
		m_arburst_i = '0;
		cycles = 0;
		while (rstn !== 1'b1) begin
			@(negedge clk);
			cycles++;
			assert (cycles <= 20) else report_error("reset never released");
		end
		assert (m_arready_o) else report_error("m_arready_o low after reset");
		assert (!m_rvalid_o) else report_error("m_rvalid_o high after reset");
		assert (!s_arvalid_o) else report_error("s_arvalid_o high after reset");
		@(posedge clk);
		#1;

		test_name = "issue_delay";
		send_read(`TGT0_ADDR_BASE + 32'h40, 4'd0, 8'd0);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= 10) else report_error("s_arvalid_o never rose");
		end while (!s_arvalid_o);
		assert (cycles == 2) else report_mismatch("ar_issue_delay", 2, cycles);
		@(posedge clk);
		#1;
		wait_drain();

		test_name = "in_window";
		for (n = 0; n < 8; n++) begin
			addr = `TGT0_ADDR_BASE + addr_t'($urandom_range(0, 255) * 16);
			send_read(addr, id_t'(n), len_t'($urandom_range(0, 15)));
		end
		wait_drain();

		test_name = "out_of_window";
		for (n = 0; n < 6; n++) begin
			addr = `TGT0_ADDR_LIMIT + 1 + addr_t'($urandom_range(0, 4095) * 16);
			send_read(addr, id_t'(n + 8), len_t'($urandom_range(0, 15)));
		end
		wait_drain();

		test_name = "window_edges";
		send_read(`TGT0_ADDR_BASE, 4'd1, 8'd1);
		send_read(`TGT0_ADDR_LIMIT, 4'd2, 8'd1);
		send_read(`TGT0_ADDR_LIMIT + 1, 4'd3, 8'd1);
		send_read(`TGT0_ADDR_BASE - 1, 4'd4, 8'd1);
		wait_drain();

		test_name = "mixed";
		for (n = 0; n < 40; n++) begin
			if ($urandom_range(0, 1) == 1) begin
				addr = `TGT0_ADDR_BASE + addr_t'($urandom_range(0, 255) * 16);
			end else begin
				addr = 32'h0001_0000 + addr_t'($urandom_range(0, 255) * 16);
			end
			send_read(addr, id_t'(n % 16), len_t'($urandom_range(0, 7)));
		end
		wait_drain();

		if (n_done == n_issued && !u_dut.u_props.fail_seen) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/rd_ic_pkg.sv
hdl/axi_rd_if.sv
hdl/rr_arbiter.sv
hdl/rd_request_stage.sv
hdl/decerr_target.sv
hdl/rd_return_mux.sv
hdl/axi_rd_interconnect.sv
sim/clk_gen.sv
sim/axi_rd_props.sv
sim/tb_axi_rd_interconnect.sv

// ==== Makefile ====
SIM ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_axi_rd_interconnect
FILE_LIST ?= sources.f
RUN_FLAGS ?= +verilator+error+limit+100

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
